//--- alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  cpu_pkg::alu_op_t op,
    output cpu_pkg::word_t   result,
    output logic             equal
);
    import cpu_pkg::*;

    // branch condition, BEQ/BNE pick the sense
    assign equal = (a == b);

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_ORR: result = a | b;
            ALU_CMP: result = word_t'(equal);
            default: result = a;   // pass
        endcase
    end

endmodule

//--- control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::word_t    instr,
    input  cpu_pkg::reg_idx_t ex_dest,
    input  cpu_pkg::reg_idx_t mem_dest,
    input  logic              ex_write,
    input  logic              mem_write_back,
    input  logic              branch_taken,
    output logic              stall,
    output logic              flush,
    output logic              fetch_en,
    output logic              dec_valid,
    output logic              reg_write,
    output logic              mem_read,
    output logic              mem_write,
    output logic              mem_to_reg,
    output logic              alu_src_imm,
    output logic              is_branch,
    output logic              branch_eq,
    output logic              is_jump,
    output logic              is_wwd,
    output logic              is_halt,
    output cpu_pkg::alu_op_t  alu_op,
    output cpu_pkg::reg_idx_t dest
);
    import cpu_pkg::*;

    typedef enum logic {
        S_RUN,
        S_HALTING
    } halt_state_t;

    halt_state_t halt_seen;
    opcode_t     opcode;
    reg_idx_t    rs, rt, rd;
    logic [5:0]  func;
    logic        use_rs, use_rt;
    logic        hazard;

    assign opcode = opcode_t'(instr[15:12]);
    assign rs     = instr[11:10];
    assign rt     = instr[9:8];
    assign rd     = instr[7:6];
    assign func   = instr[5:0];

    always_comb begin
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_to_reg  = 1'b0;
        alu_src_imm = 1'b0;
        is_branch   = 1'b0;
        branch_eq   = 1'b0;
        is_jump     = 1'b0;
        is_wwd      = 1'b0;
        is_halt     = 1'b0;
        alu_op      = ALU_PASS_A;
        dest        = rt; // i-type writes rt
        use_rs      = 1'b0;
        use_rt      = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                dest = rd;
                case (func)
                    FUNC_ADD, FUNC_SUB, FUNC_AND, FUNC_ORR: begin
                        reg_write = 1'b1;
                        use_rs    = 1'b1;
                        use_rt    = 1'b1;
                    end
                    FUNC_WWD: begin
                        is_wwd = 1'b1;
                        use_rs = 1'b1;
                    end
                    FUNC_HLT: is_halt = 1'b1;
                    default: ;
                endcase
                if (func == FUNC_ADD) alu_op = ALU_ADD;
                if (func == FUNC_SUB) alu_op = ALU_SUB;
                if (func == FUNC_AND) alu_op = ALU_AND;
                if (func == FUNC_ORR) alu_op = ALU_ORR;
            end
            OP_ADI, OP_LWD: begin
                reg_write   = 1'b1;
                mem_read    = (opcode == OP_LWD);
                mem_to_reg  = (opcode == OP_LWD);
                alu_src_imm = 1'b1;
                alu_op      = ALU_ADD;
                use_rs      = 1'b1;
            end
            OP_SWD: begin
                mem_write   = 1'b1;
                alu_src_imm = 1'b1;
                alu_op      = ALU_ADD;
                use_rs      = 1'b1;
                use_rt      = 1'b1; // store data
            end
            OP_BNE, OP_BEQ: begin
                is_branch = 1'b1;
                branch_eq = (opcode == OP_BEQ);
                alu_op    = ALU_CMP;
                use_rs    = 1'b1;
                use_rt    = 1'b1;
            end
            OP_JMP: is_jump = 1'b1;
            default: ;
        endcase
    end

    // interlock against writes still in EX and MEM, WB is written through
    assign hazard = (use_rs && ex_write && ex_dest == rs)
                 || (use_rt && ex_write && ex_dest == rt)
                 || (use_rs && mem_write_back && mem_dest == rs)
                 || (use_rt && mem_write_back && mem_dest == rt);

    assign stall     = hazard && halt_seen == S_RUN;
    assign flush     = branch_taken;
    assign fetch_en  = halt_seen == S_RUN;
    assign dec_valid = halt_seen == S_RUN; // younger than HLT are dropped

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            halt_seen <= S_RUN;
        end else if (is_halt && dec_valid && !stall && !flush) begin
            halt_seen <= S_HALTING;
        end
    end

    // a stalled or flushed decode must leave a bubble in ID/EX
    a_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        (stall || flush) |=> !ex_write);

    a_halt_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !fetch_en |=> !fetch_en);

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

    typedef logic [15:0] word_t;
    typedef logic [1:0]  reg_idx_t;

    // opcode field, instr[15:12]
    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_ADI   = 4'd4,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_RTYPE = 4'd15
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_ORR,
        ALU_PASS_A,
        ALU_CMP
    } alu_op_t;

    // func field, instr[5:0], for opcode 15
    localparam logic [5:0] FUNC_ADD = 6'd0;
    localparam logic [5:0] FUNC_SUB = 6'd1;
    localparam logic [5:0] FUNC_AND = 6'd2;
    localparam logic [5:0] FUNC_ORR = 6'd3;
    localparam logic [5:0] FUNC_WWD = 6'd28;
    localparam logic [5:0] FUNC_HLT = 6'd29;

    localparam word_t NOP_INSTR = 16'hF03F; // rtype, unused func, no effect

endpackage

//--- cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
    parameter cpu_pkg::word_t RESET_PC = '0
) (
    input  logic           clk,
    input  logic           rst_n,
    input  cpu_pkg::word_t i_data,
    input  cpu_pkg::word_t d_rdata,
    output cpu_pkg::word_t i_addr,
    output logic           i_read,
    output cpu_pkg::word_t d_addr,
    output logic           d_read,
    output logic           d_write,
    output cpu_pkg::word_t d_wdata,
    output cpu_pkg::word_t num_inst,
    output cpu_pkg::word_t output_port,
    output logic           is_halted
);
    import cpu_pkg::*;

    // hazard and flow control
    logic     stall, flush, fetch_en, dec_valid;

    // IF/ID
    word_t    if_pc, if_instr;
    logic     if_valid;

    // decoded controls
    logic     reg_write, mem_read, mem_write, mem_to_reg, alu_src_imm;
    logic     is_branch, branch_eq, is_jump, is_wwd, is_halt;
    alu_op_t  alu_op;
    reg_idx_t dest;

    // ID/EX
    logic     ex_valid, ex_mem_read, ex_mem_write, ex_mem_to_reg, ex_alu_src_imm;
    logic     ex_is_branch, ex_branch_eq, ex_is_jump, ex_is_wwd, ex_is_halt, ex_write;
    alu_op_t  ex_alu_op;
    word_t    ex_pc, ex_a, ex_b, ex_imm, wwd_data;
    reg_idx_t ex_dest;

    // EX resolve and EX/MEM
    logic     branch_taken;
    word_t    branch_target;
    logic     mem_valid, mem_write_back, mem_load, mem_is_wwd, mem_is_halt;
    word_t    mem_wwd_data, mem_result;
    reg_idx_t mem_dest;

    // WB to register file
    logic     wb_write;
    reg_idx_t wb_dest;
    word_t    wb_data;

    control_unit u_ctrl (.instr(if_instr), .*);

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (.*);

    decode_stage u_decode (.*);

    execute_stage u_execute (.*);

    writeback_stage u_writeback (.*);

endmodule

//--- decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  logic              flush,
    input  cpu_pkg::word_t    if_pc,
    input  cpu_pkg::word_t    if_instr,
    input  logic              if_valid,
    input  logic              dec_valid,
    input  logic              reg_write,
    input  logic              mem_read,
    input  logic              mem_write,
    input  logic              mem_to_reg,
    input  logic              alu_src_imm,
    input  cpu_pkg::alu_op_t  alu_op,
    input  logic              is_branch,
    input  logic              branch_eq,
    input  logic              is_jump,
    input  logic              is_wwd,
    input  logic              is_halt,
    input  cpu_pkg::reg_idx_t dest,
    input  logic              wb_write,
    input  cpu_pkg::reg_idx_t wb_dest,
    input  cpu_pkg::word_t    wb_data,
    output logic              ex_valid,
    output logic              ex_mem_read,
    output logic              ex_mem_write,
    output logic              ex_mem_to_reg,
    output logic              ex_alu_src_imm,
    output cpu_pkg::alu_op_t  ex_alu_op,
    output logic              ex_is_branch,
    output logic              ex_branch_eq,
    output logic              ex_is_jump,
    output logic              ex_is_wwd,
    output logic              ex_is_halt,
    output cpu_pkg::word_t    ex_pc,
    output cpu_pkg::word_t    ex_a,
    output cpu_pkg::word_t    ex_b,
    output cpu_pkg::word_t    ex_imm,
    output cpu_pkg::reg_idx_t ex_dest,
    output logic              ex_write,
    output cpu_pkg::word_t    wwd_data
);
    import cpu_pkg::*;

    word_t imm, da, db;
    logic  live;

    reg_file u_rf (
        .clk   (clk),
        .rst_n (rst_n),
        .ra    (if_instr[11:10]),
        .rb    (if_instr[9:8]),
        .wa    (wb_dest),
        .we    (wb_write),
        .wd    (wb_data),
        .da    (da),
        .db    (db)
    );

    // jump keeps the upper pc bits, everything else sign-extends imm8
    assign imm  = is_jump ? {if_pc[15:12], if_instr[11:0]} : {{8{if_instr[7]}}, if_instr[7:0]};
    assign live = if_valid && dec_valid && !stall && !flush;

    // ID/EX control, bubble when not live
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid     <= 1'b0;
            ex_write     <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_is_branch <= 1'b0;
            ex_is_jump   <= 1'b0;
            ex_is_wwd    <= 1'b0;
            ex_is_halt   <= 1'b0;
        end else begin
            ex_valid     <= live;
            ex_write     <= live && reg_write;
            ex_mem_read  <= live && mem_read;
            ex_mem_write <= live && mem_write;
            ex_is_branch <= live && is_branch;
            ex_is_jump   <= live && is_jump;
            ex_is_wwd    <= live && is_wwd;
            ex_is_halt   <= live && is_halt;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc          <= if_pc;
        ex_a           <= da;
        ex_b           <= db;
        ex_imm         <= imm;
        ex_dest        <= dest;
        ex_alu_op      <= alu_op;
        ex_alu_src_imm <= alu_src_imm;
        ex_mem_to_reg  <= mem_to_reg;
        ex_branch_eq   <= branch_eq;
        wwd_data       <= da;   // rs, shown by WWD at retire
    end

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ex_valid,
    input  logic              ex_mem_read,
    input  logic              ex_mem_write,
    input  logic              ex_mem_to_reg,
    input  logic              ex_alu_src_imm,
    input  cpu_pkg::alu_op_t  ex_alu_op,
    input  logic              ex_is_branch,
    input  logic              ex_branch_eq,
    input  logic              ex_is_jump,
    input  logic              ex_is_wwd,
    input  logic              ex_is_halt,
    input  cpu_pkg::word_t    ex_pc,
    input  cpu_pkg::word_t    ex_a,
    input  cpu_pkg::word_t    ex_b,
    input  cpu_pkg::word_t    ex_imm,
    input  cpu_pkg::reg_idx_t ex_dest,
    input  logic              ex_write,
    input  cpu_pkg::word_t    wwd_data,
    output logic              branch_taken,
    output cpu_pkg::word_t    branch_target,
    output cpu_pkg::reg_idx_t mem_dest,
    output logic              mem_write_back,
    output cpu_pkg::word_t    d_addr,
    output cpu_pkg::word_t    d_wdata,
    output logic              d_read,
    output logic              d_write,
    output logic              mem_valid,
    output logic              mem_load,
    output logic              mem_is_wwd,
    output logic              mem_is_halt,
    output cpu_pkg::word_t    mem_wwd_data,
    output cpu_pkg::word_t    mem_result
);
    import cpu_pkg::*;

    word_t alu_b, alu_y;
    logic  equal;

    assign alu_b = ex_alu_src_imm ? ex_imm : ex_b;

    alu u_alu (
        .a      (ex_a),
        .b      (alu_b),
        .op     (ex_alu_op),
        .result (alu_y),
        .equal  (equal)
    );

    assign branch_target = ex_is_jump ? ex_imm : ex_pc + 16'd1 + ex_imm;
    assign branch_taken  = ex_valid && (ex_is_jump || (ex_is_branch && equal == ex_branch_eq));

    assign d_addr = mem_result; // address of LWD/SWD

    // EX/MEM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_valid      <= 1'b0;
            mem_write_back <= 1'b0;
            d_read         <= 1'b0;
            d_write        <= 1'b0;
            mem_is_wwd     <= 1'b0;
            mem_is_halt    <= 1'b0;
        end else begin
            mem_valid      <= ex_valid;
            mem_write_back <= ex_write;
            d_read         <= ex_mem_read;
            d_write        <= ex_mem_write;
            mem_is_wwd     <= ex_is_wwd;
            mem_is_halt    <= ex_is_halt;
        end
    end

    always_ff @(posedge clk) begin
        mem_result   <= alu_y;
        d_wdata      <= ex_b;   // rt for SWD
        mem_dest     <= ex_dest;
        mem_load     <= ex_mem_to_reg;
        mem_wwd_data <= wwd_data;
    end

endmodule

//--- fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
    parameter cpu_pkg::word_t RESET_PC = '0
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           stall,
    input  logic           flush,
    input  logic           fetch_en,
    input  logic           branch_taken,
    input  cpu_pkg::word_t branch_target,
    input  cpu_pkg::word_t i_data,
    output cpu_pkg::word_t i_addr,
    output cpu_pkg::word_t if_pc,
    output cpu_pkg::word_t if_instr,
    output logic           i_read,
    output logic           if_valid
);
    import cpu_pkg::*;

    word_t pc;

    assign i_addr = pc;
    assign i_read = fetch_en;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (branch_taken) begin
            pc <= branch_target;
        end else if (fetch_en && !stall) begin
            pc <= pc + 16'd1;
        end
    end

    // IF/ID
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            if_valid <= 1'b0;
            if_instr <= NOP_INSTR;
        end else if (!stall) begin
            if_valid <= fetch_en;
            if_instr <= fetch_en ? i_data : NOP_INSTR;
            if_pc    <= pc;
        end
    end

    a_pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (stall && !branch_taken) |=> pc == $past(pc));

endmodule

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::reg_idx_t ra,
    input  cpu_pkg::reg_idx_t rb,
    input  cpu_pkg::reg_idx_t wa,
    input  logic              we,
    input  cpu_pkg::word_t    wd,
    output cpu_pkg::word_t    da,
    output cpu_pkg::word_t    db
);
    import cpu_pkg::*;

    word_t regs [4];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

    // write-through, same-cycle WB is visible to ID
    assign da = (we && wa == ra) ? wd : regs[ra];
    assign db = (we && wa == rb) ? wd : regs[rb];

endmodule

//--- run.sh
#!/bin/sh
# build and run the cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        -f sources.f --top-module tb_cpu; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
    exit 0
fi
exit 1

//--- sources.f
+incdir+.
cpu_pkg.sv
alu.sv
reg_file.sv
control_unit.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
writeback_stage.sv
cpu_top.sv
tb_cpu.sv

//--- tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam int MODE_CHAIN  = 0;
localparam int MODE_MEM    = 1;
localparam int MODE_BRANCH = 2;
localparam int MODE_MIX    = 3;

localparam int K_ALU = 0;
localparam int K_ADI = 1;
localparam int K_LWD = 2;
localparam int K_SWD = 3;
localparam int K_BR  = 4;
localparam int K_JMP = 5;

localparam logic [5:0] ALU_FUNCS [4] = '{FUNC_ADD, FUNC_SUB, FUNC_AND, FUNC_ORR};

// expected stores, output_port changes and retired count of the current program
word_t exp_st_addr[$];
word_t exp_st_data[$];
word_t exp_port[$];
word_t exp_count;

// odd multiplier keeps every word distinct
function automatic word_t fill_word(int a);
    return word_t'(a * 40503) ^ 16'hA5C3;
endfunction

function automatic word_t enc_r(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd, logic [5:0] func);
    return {OP_RTYPE, rs, rt, rd, func};
endfunction

function automatic word_t enc_i(opcode_t op, reg_idx_t rs, reg_idx_t rt, logic [7:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic int pick_kind(int mode);
    int r;
    r = $urandom_range(0, 5);
    case (mode)
        MODE_CHAIN:  return (r < 4) ? K_ALU : K_ADI;
        MODE_MEM:    return (r == 0) ? K_ALU : (r == 1) ? K_ADI : (r < 4) ? K_LWD : K_SWD;
        MODE_BRANCH: return (r == 0) ? K_ALU : (r == 1) ? K_ADI : (r < 5) ? K_BR : K_JMP;
        default:     return r; // every kind equally likely
    endcase
endfunction

// forward-only control flow, so every program reaches its epilogue
task automatic gen_program(int mode);
    int len, pc, kind, off, lim;
    reg_idx_t last, rs, rt, rd, sel;
    opcode_t op;
    len  = $urandom_range(36, 44);
    last = 2'd0;
    for (pc = 0; pc < 256; pc++) begin
        imem[pc[7:0]] = enc_r(2'd0, 2'd0, 2'd0, FUNC_HLT);
    end
    for (pc = 0; pc < len; pc++) begin
        rs   = reg_idx_t'($urandom_range(0, 3));
        rt   = reg_idx_t'($urandom_range(0, 3));
        rd   = reg_idx_t'($urandom_range(0, 3));
        sel  = reg_idx_t'($urandom_range(0, 3));
        lim  = (len - 1 - pc < 5) ? len - 1 - pc : 5;
        off  = $urandom_range(0, lim);
        kind = pick_kind(mode);
        if (mode == MODE_CHAIN || $urandom_range(0, 2) == 0) begin
            rs = last; // read the latest result
        end
        case (kind)
            K_ALU: begin
                imem[pc[7:0]] = enc_r(rs, rt, rd, ALU_FUNCS[sel]);
                last = rd;
            end
            K_ADI: begin
                imem[pc[7:0]] = enc_i(OP_ADI, rs, rt, 8'($urandom_range(0, 255)));
                last = rt;
            end
            K_LWD: begin
                imem[pc[7:0]] = enc_i(OP_LWD, rs, rt, 8'($urandom_range(0, 15)));
                last = rt;
            end
            K_SWD: imem[pc[7:0]] = enc_i(OP_SWD, rs, rt, 8'($urandom_range(0, 15)));
            K_BR: begin
                op = ($urandom_range(0, 1) == 0) ? OP_BNE : OP_BEQ;
                if ($urandom_range(0, 2) == 0) begin
                    rt = rs; // outcome fixed by the opcode
                end
                imem[pc[7:0]] = enc_i(op, rs, rt, 8'(off));
            end
            default: imem[pc[7:0]] = {OP_JMP, 12'(pc + 1 + off)};
        endcase
    end
    // WWD of every register, the HLT after them comes from the fill
    for (pc = 0; pc < 4; pc++) begin
        imem[8'(len + pc)] = enc_r(reg_idx_t'(pc), 2'd0, 2'd0, FUNC_WWD);
    end
endtask

// instruction-level interpreter of the program in imem
task automatic run_model;
    word_t r [4];
    word_t m [256];
    word_t pc, nxt, ins, imm, addr, cur;
    reg_idx_t rs, rt, rd;
    int a, steps;
    bit done;
    for (a = 0; a < 256; a++) begin
        m[a[7:0]] = fill_word(a);
    end
    for (a = 0; a < 4; a++) begin
        r[a[1:0]] = '0;
    end
    exp_st_addr.delete();
    exp_st_data.delete();
    exp_port.delete();
    pc        = RESET_PC;
    cur       = '0;
    exp_count = '0;
    steps     = 0;
    done      = 1'b0;
    while (!done && steps < 512) begin
        ins  = imem[pc[7:0]];
        rs   = ins[11:10];
        rt   = ins[9:8];
        rd   = ins[7:6];
        imm  = {{8{ins[7]}}, ins[7:0]};
        addr = r[rs] + imm;       // memory address, also the ADI sum
        nxt  = pc + 16'd1;
        exp_count = exp_count + 16'd1; // HLT counts too
        steps++;
        case (opcode_t'(ins[15:12]))
            OP_RTYPE: begin
                case (ins[5:0])
                    FUNC_ADD: r[rd] = r[rs] + r[rt];
                    FUNC_SUB: r[rd] = r[rs] - r[rt];
                    FUNC_AND: r[rd] = r[rs] & r[rt];
                    FUNC_ORR: r[rd] = r[rs] | r[rt];
                    FUNC_WWD: begin
                        if (r[rs] != cur) begin
                            exp_port.push_back(r[rs]);
                        end
                        cur = r[rs];
                    end
                    FUNC_HLT: done = 1'b1;
                    default: ;
                endcase
            end
            OP_ADI: r[rt] = addr;
            OP_LWD: r[rt] = m[addr[7:0]];
            OP_SWD: begin
                m[addr[7:0]] = r[rt];
                exp_st_addr.push_back(addr);
                exp_st_data.push_back(r[rt]);
            end
            OP_BNE: nxt = (r[rs] != r[rt]) ? nxt + imm : nxt;
            OP_BEQ: nxt = (r[rs] == r[rt]) ? nxt + imm : nxt;
            OP_JMP: nxt = {pc[15:12], ins[11:0]};
            default: ;
        endcase
        pc = nxt;
    end
endtask

`endif

//--- tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;
    import cpu_pkg::*;

    localparam word_t RESET_PC = 16'h0000;
    localparam int    TIMEOUT  = 2000;

    logic  clk, rst_n;
    word_t i_data, d_rdata, i_addr, d_addr, d_wdata, num_inst, output_port;
    logic  i_read, d_read, d_write, is_halted;

    word_t imem [256];
    word_t dmem [256];
    word_t st_addr_q[$];
    word_t st_data_q[$];
    word_t port_q[$];
    word_t last_port;
    int    errors, tests;

    `include "tb_model.svh"

    cpu_top #(.RESET_PC(RESET_PC)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // both memories answer in the same cycle, indexed by the low address byte
    assign i_data  = imem[i_addr[7:0]];
    assign d_rdata = dmem[d_addr[7:0]];

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int a = 0; a < 256; a++) begin
                dmem[a[7:0]] <= fill_word(a);
            end
            st_addr_q.delete();
            st_data_q.delete();
        end else if (d_write) begin
            dmem[d_addr[7:0]] <= d_wdata;
            st_addr_q.push_back(d_addr);
            st_data_q.push_back(d_wdata);
        end
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            port_q.delete();
            last_port = '0;
        end else if (output_port !== last_port) begin
            port_q.push_back(output_port);
            last_port = output_port;
        end
    end

    task automatic check(string name, word_t got, word_t want);
        if (got !== want) begin
            $display("Fail %s: got %h, expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic check_idle(string when);
        check($sformatf("is_halted %s", when), word_t'(is_halted), 16'h0000);
        check($sformatf("d_write %s", when), word_t'(d_write), 16'h0000);
        check($sformatf("d_read %s", when), word_t'(d_read), 16'h0000);
        check($sformatf("i_read %s", when), word_t'(i_read), 16'h0001);
        check($sformatf("num_inst %s", when), num_inst, 16'h0000);
        check($sformatf("output_port %s", when), output_port, 16'h0000);
        check($sformatf("i_addr %s", when), i_addr, RESET_PC);
    endtask

    task automatic start_reset;
        @(posedge clk);
        #1;
        rst_n = 1'b0;
    endtask

    task automatic finish_reset;
        repeat (5) @(posedge clk);
        #1;
        check_idle("during reset");
        rst_n = 1'b1;
        @(negedge clk);
        check_idle("after reset");
    endtask

    task automatic compare_logs;
        int k;
        check("store count", word_t'(st_addr_q.size()), word_t'(exp_st_addr.size()));
        for (k = 0; k < st_addr_q.size() && k < exp_st_addr.size(); k++) begin
            check($sformatf("d_addr[%0d]", k), st_addr_q[k], exp_st_addr[k]);
            check($sformatf("d_wdata[%0d]", k), st_data_q[k], exp_st_data[k]);
        end
        check("output_port changes", word_t'(port_q.size()), word_t'(exp_port.size()));
        for (k = 0; k < port_q.size() && k < exp_port.size(); k++) begin
            check($sformatf("output_port[%0d]", k), port_q[k], exp_port[k]);
        end
    endtask

    task automatic report(string label, int start_err);
        if (errors == start_err) begin
            $display("test %0d %s: ok", tests, label);
        end else begin
            $display("test %0d %s: %0d errors", tests, label, errors - start_err);
        end
    endtask

    task automatic run_program(string label, int mode);
        int start_err, n;
        word_t hold_count, hold_port, hold_pc;
        start_err = errors;
        tests++;
        start_reset();
        gen_program(mode); // loaded while the core sits in reset
        run_model();
        finish_reset();
        n = 0;
        while (!is_halted && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!is_halted) begin
            $display("test %0d %s: core never halted within %0d cycles", tests, label, TIMEOUT);
            errors++;
        end else begin
            check("num_inst", num_inst, exp_count);
            hold_count = num_inst;
            hold_port  = output_port;
            hold_pc    = i_addr;
            repeat (20) begin
                @(negedge clk);
                check("num_inst after halt", num_inst, hold_count);
                check("output_port after halt", output_port, hold_port);
                check("d_write after halt", word_t'(d_write), 16'h0000);
                check("d_read after halt", word_t'(d_read), 16'h0000);
                check("i_read after halt", word_t'(i_read), 16'h0000);
                check("i_addr after halt", i_addr, hold_pc);
            end
            compare_logs();
        end
        report(label, start_err);
    endtask

    initial begin
        int i, a;
        void'($urandom(91331));
        errors   = 0;
        tests    = 0;
        rst_n    = 1'b0;
        for (a = 0; a < 256; a++) begin
            imem[a[7:0]] = enc_r(2'd0, 2'd0, 2'd0, FUNC_HLT);
        end

        tests++;
        start_reset();
        finish_reset();
        report("reset", 0);

        for (i = 0; i < 10; i++) begin
            run_program("dependent chain", MODE_CHAIN);
        end
        for (i = 0; i < 5; i++) begin
            run_program("loads and stores", MODE_MEM);
        end
        for (i = 0; i < 5; i++) begin
            run_program("branches and jumps", MODE_BRANCH);
        end
        for (i = 0; i < 20; i++) begin
            run_program("mixed", MODE_MIX);
        end

        $display("errors: %0d, tests: %0d", errors, tests);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              mem_valid,
    input  logic              mem_write_back,
    input  cpu_pkg::reg_idx_t mem_dest,
    input  logic              mem_load,
    input  logic              mem_is_wwd,
    input  logic              mem_is_halt,
    input  cpu_pkg::word_t    mem_wwd_data,
    input  cpu_pkg::word_t    mem_result,
    input  cpu_pkg::word_t    d_rdata,
    output logic              wb_write,
    output cpu_pkg::reg_idx_t wb_dest,
    output cpu_pkg::word_t    wb_data,
    output cpu_pkg::word_t    num_inst,
    output cpu_pkg::word_t    output_port,
    output logic              is_halted
);
    import cpu_pkg::*;

    logic  wb_valid, wb_is_wwd, wb_is_halt, wb_load;
    word_t wb_result, wb_rdata, wb_wwd_data;

    // MEM/WB
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid   <= 1'b0;
            wb_write   <= 1'b0;
            wb_is_wwd  <= 1'b0;
            wb_is_halt <= 1'b0;
        end else begin
            wb_valid   <= mem_valid;
            wb_write   <= mem_write_back;
            wb_is_wwd  <= mem_is_wwd;
            wb_is_halt <= mem_is_halt;
        end
    end

    always_ff @(posedge clk) begin
        wb_dest     <= mem_dest;
        wb_load     <= mem_load;
        wb_result   <= mem_result;
        wb_rdata    <= d_rdata;
        wb_wwd_data <= mem_wwd_data;
    end

    assign wb_data = wb_load ? wb_rdata : wb_result;

    // retire point
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            num_inst    <= '0;
            output_port <= '0;
            is_halted   <= 1'b0;
        end else if (wb_valid) begin
            num_inst <= num_inst + 16'd1;
            if (wb_is_wwd) output_port <= wb_wwd_data;
            if (wb_is_halt) is_halted <= 1'b1;   // sticky until reset
        end
    end

    // nothing younger than HLT may reach retire
    a_no_retire_halted: assert property (@(posedge clk) disable iff (!rst_n)
        is_halted |=> $stable(num_inst));

endmodule
